/* Bender.yml */
package:
  name: cpu_core

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - src/cpu_pkg.sv
      - src/phase_sequencer.sv
      - src/instr_decoder.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/pc_unit.sv
      - src/cpu_core.sv
  # Testbench with its included reference model
  - target: test
    include_dirs:
      - include
    files:
      - verif/cpu_tb.sv

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic CLK,
	input logic rst_n,
	input cpu_pkg::proc_phase_e phase,
	input cpu_pkg::alu_op_e alu_op,
	input cpu_pkg::word_t op_a,
	input cpu_pkg::word_t op_b,
	output cpu_pkg::word_t result,
	output logic zero
);
	import cpu_pkg::*;

	word_t result_c;

	// ------------------------------
	// Operation select
	always_comb begin
		case (alu_op)
			ALU_ADD: result_c = op_a + op_b;
			ALU_SUB: result_c = op_a - op_b;
			ALU_AND: result_c = op_a & op_b;
			ALU_OR: result_c = op_a | op_b;
			ALU_NOR: result_c = ~(op_a | op_b);
			// Signed compare
			ALU_SLT: result_c = {31'd0, $signed(op_a) < $signed(op_b)};
			// Shift amount in the low five bits
			ALU_SLL: result_c = op_a << op_b[4:0];
			ALU_SRL: result_c = op_a >> op_b[4:0];
			default: result_c = '0;
		endcase
	end

	// Result and flag frozen at end of EXE
	// MEM address and WB data read them from here
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			zero <= 1'b0;
		end else if (phase == PH_EXE) begin
			result <= result_c;
			zero <= (result_c == '0);
		end
	end

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic CLK,
	input logic rst_n,
	output cpu_pkg::mem_req_t mem_req,
	input cpu_pkg::word_t mem_rdata
);
	import cpu_pkg::*;

	proc_phase_e phase;
	dec_ctrl_t ctrl;
	word_t rs_data;
	word_t rt_data;
	word_t alu_op_b;
	word_t alu_result;
	logic zero;
	word_t pc;
	word_t wb_data;
	logic rf_wr_en;

	// ------------------------------
	// Sequencing and decode
	phase_sequencer u_phase_sequencer (
		.CLK(CLK),
		.rst_n(rst_n),
		.phase(phase)
	);

	// Instruction word arrives during DECODE
	instr_decoder u_instr_decoder (
		.CLK(CLK),
		.rst_n(rst_n),
		.phase(phase),
		.instr(mem_rdata),
		.ctrl(ctrl)
	);

	// ------------------------------
	// Datapath
	reg_file u_reg_file (
		.CLK(CLK),
		.rst_n(rst_n),
		.rd_idx_a(ctrl.rs),
		.rd_idx_b(ctrl.rt),
		.rd_data_a(rs_data),
		.rd_data_b(rt_data),
		.wr_en(rf_wr_en),
		.wr_idx(ctrl.dest),
		.wr_data(wb_data)
	);

	// Second operand mux
	always_comb begin
		case (ctrl.op2_sel)
			OP2_RT: alu_op_b = rt_data;
			OP2_SIMM: alu_op_b = {{16{ctrl.imm[15]}}, ctrl.imm};
			OP2_ZIMM: alu_op_b = {16'd0, ctrl.imm};
			// shamt sits in imm[10:6]
			default: alu_op_b = {27'd0, ctrl.imm[10:6]};
		endcase
	end

	alu u_alu (
		.CLK(CLK),
		.rst_n(rst_n),
		.phase(phase),
		.alu_op(ctrl.alu_op),
		.op_a(rs_data),
		.op_b(alu_op_b),
		.result(alu_result),
		.zero(zero)
	);

	pc_unit #(
		.RESET_PC(RESET_PC)
	) u_pc_unit (
		.CLK(CLK),
		.rst_n(rst_n),
		.phase(phase),
		.ctrl(ctrl),
		.zero(zero),
		.pc(pc)
	);

	// ------------------------------
	// Memory strobes, one cycle each
	always_comb begin
		mem_req = '0;
		case (phase)
			PH_FETCH: begin
				// No fetch while held in reset
				mem_req.rd = rst_n;
				mem_req.addr = pc;
			end
			PH_MEM: begin
				mem_req.rd = ctrl.is_load;
				mem_req.wr = ctrl.is_store;
				mem_req.addr = alu_result;
				mem_req.wdata = rt_data;
			end
			default: ;
		endcase
	end

	// Writeback source, load data valid during WB
	assign wb_data = ctrl.is_lui ? {ctrl.imm, 16'd0}
		: (ctrl.is_load ? mem_rdata : alu_result);
	assign rf_wr_en = (phase == PH_WB) && ctrl.writes_reg;

	// Never a read and a write together
	a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!rst_n)
		!(mem_req.rd && mem_req.wr));

	// Store three cycles after its fetch, gone by WB
	a_wr_in_mem: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_req.wr |-> $past(mem_req.rd, 3) ##1 !mem_req.wr);

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

	// Data word and instruction fields
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// ------------------------------
	// Opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J = 6'h02;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_BNE = 6'h05;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_SLTI = 6'h0a;
	localparam opcode_t OP_ANDI = 6'h0c;
	localparam opcode_t OP_ORI = 6'h0d;
	localparam opcode_t OP_LUI = 6'h0f;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;

	// Funct values under OP_RTYPE
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;

	// ------------------------------
	// ALU operation codes
	typedef enum logic [3:0] {
		ALU_ADD = 4'h1,
		ALU_SUB = 4'h2,
		ALU_SRL = 4'h4,
		ALU_SLL = 4'h5,
		ALU_AND = 4'h6,
		ALU_OR = 4'h7,
		ALU_NOR = 4'h8,
		ALU_SLT = 4'h9
	} alu_op_e;

	// Source of the second ALU operand
	typedef enum logic [1:0] {
		OP2_RT,
		OP2_SIMM,
		OP2_ZIMM,
		OP2_SHAMT
	} op2_sel_e;

	// Five phases per instruction
	typedef enum logic [2:0] {
		PH_FETCH = 3'd0,
		PH_DECODE = 3'd1,
		PH_EXE = 3'd2,
		PH_MEM = 3'd3,
		PH_WB = 3'd4
	} proc_phase_e;

	// Decoded instruction, held from one DECODE to the next
	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		alu_op_e alu_op;
		op2_sel_e op2_sel;
		logic [15:0] imm;
		logic [25:0] jump_target;
		logic writes_reg;
		logic is_load;
		logic is_store;
		logic is_beq;
		logic is_bne;
		logic is_jump;
		logic is_lui;
	} dec_ctrl_t;

	// Request to the word-addressed memory
	typedef struct packed {
		logic rd;
		logic wr;
		word_t addr;
		word_t wdata;
	} mem_req_t;

endpackage

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input logic CLK,
	input logic rst_n,
	input cpu_pkg::proc_phase_e phase,
	input cpu_pkg::word_t instr,
	output cpu_pkg::dec_ctrl_t ctrl
);
	import cpu_pkg::*;

	opcode_t opcode;
	funct_t funct;
	dec_ctrl_t dec;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	// ------------------------------
	// Field split and class decode
	always_comb begin
		dec = '0;
		dec.rs = instr[25:21];
		dec.rt = instr[20:16];
		// I-type writes rt
		dec.dest = instr[20:16];
		dec.imm = instr[15:0];
		dec.jump_target = instr[25:0];
		dec.alu_op = ALU_ADD;
		dec.op2_sel = OP2_SIMM;
		case (opcode)
			OP_RTYPE: begin
				// R-type writes rd
				dec.dest = instr[15:11];
				dec.op2_sel = OP2_RT;
				dec.writes_reg = 1'b1;
				case (funct)
					FN_ADD: dec.alu_op = ALU_ADD;
					FN_SUB: dec.alu_op = ALU_SUB;
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR: dec.alu_op = ALU_OR;
					FN_NOR: dec.alu_op = ALU_NOR;
					FN_SLT: dec.alu_op = ALU_SLT;
					FN_SLL: begin
						dec.alu_op = ALU_SLL;
						dec.op2_sel = OP2_SHAMT;
					end
					FN_SRL: begin
						dec.alu_op = ALU_SRL;
						dec.op2_sel = OP2_SHAMT;
					end
					// Unknown funct, no write
					default: dec.writes_reg = 1'b0;
				endcase
			end
			OP_ADDI: dec.writes_reg = 1'b1;
			OP_ANDI: begin
				dec.writes_reg = 1'b1;
				dec.alu_op = ALU_AND;
				dec.op2_sel = OP2_ZIMM;
			end
			OP_ORI: begin
				dec.writes_reg = 1'b1;
				dec.alu_op = ALU_OR;
				dec.op2_sel = OP2_ZIMM;
			end
			OP_SLTI: begin
				dec.writes_reg = 1'b1;
				dec.alu_op = ALU_SLT;
			end
			OP_LUI: begin
				dec.writes_reg = 1'b1;
				dec.is_lui = 1'b1;
			end
			// Address is rs plus sign-extended imm
			OP_LW: begin
				dec.writes_reg = 1'b1;
				dec.is_load = 1'b1;
			end
			OP_SW: dec.is_store = 1'b1;
			// Branches compare by subtraction
			OP_BEQ: begin
				dec.alu_op = ALU_SUB;
				dec.op2_sel = OP2_RT;
				dec.is_beq = 1'b1;
			end
			OP_BNE: begin
				dec.alu_op = ALU_SUB;
				dec.op2_sel = OP2_RT;
				dec.is_bne = 1'b1;
			end
			OP_J: dec.is_jump = 1'b1;
			// Anything else only steps the PC
			default: ;
		endcase
	end

	// Instruction register, decoded form
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (phase == PH_DECODE) begin
			ctrl <= dec;
		end
	end

endmodule

/* src/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic CLK,
	input logic rst_n,
	input cpu_pkg::proc_phase_e phase,
	input cpu_pkg::dec_ctrl_t ctrl,
	input logic zero,
	output cpu_pkg::word_t pc
);
	import cpu_pkg::*;

	word_t pc_seq;
	word_t pc_branch;
	word_t pc_jump;
	word_t pc_nxt;
	logic branch_taken;

	// Candidate targets
	assign pc_seq = pc + 32'd1;
	// Branch offset counts from pc+1
	assign pc_branch = pc_seq + {{16{ctrl.imm[15]}}, ctrl.imm};
	assign pc_jump = {6'd0, ctrl.jump_target};

	// zero comes from rs - rt in EXE
	assign branch_taken = (ctrl.is_beq && zero) || (ctrl.is_bne && !zero);

	// ------------------------------
	// Next PC select
	always_comb begin
		if (ctrl.is_jump) begin
			pc_nxt = pc_jump;
		end else if (branch_taken) begin
			pc_nxt = pc_branch;
		end else begin
			pc_nxt = pc_seq;
		end
	end

	// Update once per instruction
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (phase == PH_WB) begin
			pc <= pc_nxt;
		end
	end

endmodule

/* src/phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer (
	input logic CLK,
	input logic rst_n,
	output cpu_pkg::proc_phase_e phase
);
	import cpu_pkg::*;

	proc_phase_e phase_nxt;

	// Fixed ring, no stall input
	always_comb begin
		case (phase)
			PH_FETCH: phase_nxt = PH_DECODE;
			PH_DECODE: phase_nxt = PH_EXE;
			PH_EXE: phase_nxt = PH_MEM;
			PH_MEM: phase_nxt = PH_WB;
			// WB and any stray code fall back to FETCH
			default: phase_nxt = PH_FETCH;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_FETCH;
		end else begin
			phase <= phase_nxt;
		end
	end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input logic CLK,
	input logic rst_n,
	input cpu_pkg::reg_idx_t rd_idx_a,
	input cpu_pkg::reg_idx_t rd_idx_b,
	output cpu_pkg::word_t rd_data_a,
	output cpu_pkg::word_t rd_data_b,
	input logic wr_en,
	input cpu_pkg::reg_idx_t wr_idx,
	input cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	localparam int unsigned NUM_REGS = 32;

	// Storage, r0 is an ordinary register here
	word_t regs [NUM_REGS];

	// Async clear, one write port
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// ------------------------------
	// Combinational read ports
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

/* include/isa_ref_model.svh */
`ifndef ISA_REF_MODEL_SVH
`define ISA_REF_MODEL_SVH

// Included in the cpu_tb body after import cpu_pkg::*

// ------------------------------
// Memory map and model state
localparam int unsigned MEM_WORDS = 1024;
localparam int unsigned DATA_BASE = 256;
localparam int unsigned DATA_WORDS = 256;
localparam word_t LFSR_SEED = 32'd86389;

word_t ref_mem [MEM_WORDS];
word_t ref_regs [32];
word_t ref_pc;

// Fibonacci LFSR, taps 32 22 2 1
function automatic word_t lfsr_next(input word_t x);
	return {x[30:0], x[31] ^ x[21] ^ x[1] ^ x[0]};
endfunction

// Encoders, register fields as plain ints
function automatic word_t enc_r(input funct_t fn, input int rs, input int rt,
		input int rd, input int sh);
	return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input int rs, input int rt, input int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// ------------------------------
// Data region and program image
function automatic void ref_init(input word_t reset_pc);
	word_t lfsr;
	int unsigned p;
	lfsr = LFSR_SEED;
	foreach (ref_regs[i]) ref_regs[i] = '0;
	foreach (ref_mem[i]) ref_mem[i] = '0;
	// One LFSR step per data bit
	for (int i = 0; i < DATA_WORDS; i++) begin
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsr_next(lfsr);
			ref_mem[DATA_BASE + i][b] = lfsr[0];
		end
	end
	ref_pc = reset_pc;
	p = reset_pc;
	ref_mem[p++] = enc_i(OP_ADDI, 0, 1, DATA_BASE);
	// lw then sw of an LFSR word
	ref_mem[p++] = enc_i(OP_LW, 1, 2, 3);
	ref_mem[p++] = enc_i(OP_SW, 1, 2, 64);
	ref_mem[p++] = enc_i(OP_ADDI, 0, 3, -5);
	ref_mem[p++] = enc_i(OP_ORI, 0, 4, 16'h8001);
	ref_mem[p++] = enc_i(OP_ANDI, 3, 5, 16'hF0F0);
	ref_mem[p++] = enc_i(OP_LUI, 0, 6, 16'h1234);
	ref_mem[p++] = enc_r(FN_ADD, 6, 4, 7, 0);
	ref_mem[p++] = enc_r(FN_SUB, 4, 3, 8, 0);
	ref_mem[p++] = enc_r(FN_AND, 2, 3, 9, 0);
	ref_mem[p++] = enc_r(FN_OR, 6, 3, 10, 0);
	ref_mem[p++] = enc_r(FN_NOR, 2, 4, 11, 0);
	ref_mem[p++] = enc_r(FN_SLT, 3, 4, 12, 0);
	ref_mem[p++] = enc_i(OP_SLTI, 3, 13, -2);
	ref_mem[p++] = enc_r(FN_SLL, 4, 0, 14, 4);
	ref_mem[p++] = enc_r(FN_SRL, 3, 0, 15, 8);
	// Dump r3..r15 for the store checks
	for (int r = 3; r < 16; r++) ref_mem[p++] = enc_i(OP_SW, 1, r, 64 + r);
	// Unknown opcode
	ref_mem[p++] = 32'hFC00_0000;
	// beq taken, bne not taken, beq not taken, bne taken
	ref_mem[p++] = enc_i(OP_BEQ, 0, 0, 1);
	ref_mem[p++] = enc_i(OP_SW, 1, 3, 100);
	ref_mem[p++] = enc_i(OP_BNE, 0, 0, 1);
	ref_mem[p++] = enc_i(OP_ADDI, 0, 16, 7);
	ref_mem[p++] = enc_i(OP_BEQ, 3, 4, 1);
	ref_mem[p++] = enc_i(OP_BNE, 3, 4, 1);
	ref_mem[p++] = enc_i(OP_SW, 1, 16, 101);
	ref_mem[p++] = enc_i(OP_SW, 1, 16, 102);
	// Park on a jump to itself
	ref_mem[p] = {OP_J, p[25:0]};
endfunction

// ------------------------------
// One instruction of the reference
function automatic void ref_step(output word_t fetch_addr, output bit st_en,
		output word_t st_addr, output word_t st_data);
	word_t ins;
	word_t a;
	word_t b;
	word_t simm;
	word_t zimm;
	word_t ea;
	fetch_addr = ref_pc;
	ins = ref_mem[ref_pc[9:0]];
	a = ref_regs[ins[25:21]];
	b = ref_regs[ins[20:16]];
	simm = {{16{ins[15]}}, ins[15:0]};
	zimm = {16'd0, ins[15:0]};
	ea = a + simm;
	st_en = 1'b0;
	st_addr = '0;
	st_data = '0;
	ref_pc = ref_pc + 32'd1;
	case (opcode_t'(ins[31:26]))
		OP_RTYPE: begin
			case (funct_t'(ins[5:0]))
				FN_ADD: ref_regs[ins[15:11]] = a + b;
				FN_SUB: ref_regs[ins[15:11]] = a - b;
				FN_AND: ref_regs[ins[15:11]] = a & b;
				FN_OR: ref_regs[ins[15:11]] = a | b;
				FN_NOR: ref_regs[ins[15:11]] = ~(a | b);
				FN_SLT: ref_regs[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
				FN_SLL: ref_regs[ins[15:11]] = a << ins[10:6];
				FN_SRL: ref_regs[ins[15:11]] = a >> ins[10:6];
				default: ;
			endcase
		end
		OP_ADDI: ref_regs[ins[20:16]] = ea;
		OP_ANDI: ref_regs[ins[20:16]] = a & zimm;
		OP_ORI: ref_regs[ins[20:16]] = a | zimm;
		OP_SLTI: ref_regs[ins[20:16]] = {31'd0, $signed(a) < $signed(simm)};
		OP_LUI: ref_regs[ins[20:16]] = {ins[15:0], 16'd0};
		OP_LW: ref_regs[ins[20:16]] = ref_mem[ea[9:0]];
		OP_SW: begin
			st_en = 1'b1;
			st_addr = ea;
			st_data = b;
			ref_mem[ea[9:0]] = b;
		end
		OP_BEQ: if (a == b) ref_pc = ref_pc + simm;
		OP_BNE: if (a != b) ref_pc = ref_pc + simm;
		OP_J: ref_pc = {6'd0, ins[25:0]};
		default: ;
	endcase
endfunction

`endif

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	// Program image, LFSR data and reference step
	`include "isa_ref_model.svh"

	localparam word_t RESET_PC = 32'd16;
	localparam int unsigned NUM_INSTR = 42;
	localparam int unsigned REQ_TIMEOUT = 8;

	logic CLK;
	logic rst_n;
	mem_req_t mem_req;
	word_t mem_rdata;

	// Memory model state
	word_t dut_mem [MEM_WORDS];
	mem_req_t req_q;

	cpu_core #(
		.RESET_PC(RESET_PC)
	) u_cpu_core (
		.CLK(CLK),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata)
	);

	// 40 ns period
	always #20 CLK = ~CLK;

	// ------------------------------
	// Memory model
	// Request taken mid-cycle, where it is settled
	always @(negedge CLK) begin
		req_q <= mem_req;
	end

	// Write at the edge, read data 2 ns later and held
	always @(posedge CLK) begin
		if (req_q.wr) begin
			dut_mem[req_q.addr[9:0]] <= req_q.wdata;
		end
		if (req_q.rd) begin
			mem_rdata <= #2 dut_mem[req_q.addr[9:0]];
		end
	end

	// ------------------------------
	// Failure exit
	task automatic fail_run(input string line);
		$display("%s", line);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at first failure");
	endtask

	// Next cycle with a strobe, idle counts the empty cycles
	task automatic wait_request(output int idle);
		bit seen;
		idle = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge CLK);
			if (mem_req.rd || mem_req.wr) begin
				seen = 1'b1;
			end else begin
				idle++;
				if (idle > REQ_TIMEOUT) begin
					fail_run("The core stalled: no memory request for too many cycles");
				end
			end
		end
	endtask

	// Strobes, then address and data where they matter
	task automatic check_request(input bit exp_rd, input bit exp_wr, input word_t exp_addr,
			input word_t exp_data, input string what);
		assert (mem_req.rd == exp_rd && mem_req.wr == exp_wr) else
			fail_run($sformatf("** Error @ %0t: %s rd/wr expected %b/%b, got %b/%b",
				$time, what, exp_rd, exp_wr, mem_req.rd, mem_req.wr));
		if (exp_rd || exp_wr) begin
			assert (mem_req.addr == exp_addr) else
				fail_run($sformatf("** Error @ %0t: %s address expected %0d, got %0d",
					$time, what, exp_addr, mem_req.addr));
		end
		if (exp_wr) begin
			assert (mem_req.wdata == exp_data) else
				fail_run($sformatf("** Error @ %0t: %s data expected %h, got %h",
					$time, what, exp_data, mem_req.wdata));
		end
	endtask

	// ------------------------------
	// Stimulus and compare
	initial begin
		word_t ins;
		word_t exp_fetch;
		word_t st_addr;
		word_t st_data;
		word_t ld_addr;
		bit st_en;
		bit is_lw;
		int idle;
		CLK = 1'b0;
		rst_n = 1'b0;
		mem_rdata = '0;
		req_q = '0;
		ref_init(RESET_PC);
		// Same image and LFSR data on both sides
		foreach (dut_mem[i]) dut_mem[i] = ref_mem[i];

		// Quiet bus through reset
		repeat (5) begin
			@(negedge CLK);
			check_request(1'b0, 1'b0, '0, '0, "reset");
		end
		@(posedge CLK);
		#2 rst_n = 1'b1;

		for (int n = 0; n < NUM_INSTR; n++) begin
			// Load address from the model state before the step
			ins = ref_mem[ref_pc[9:0]];
			is_lw = (opcode_t'(ins[31:26]) == OP_LW);
			ld_addr = ref_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
			ref_step(exp_fetch, st_en, st_addr, st_data);

			// Fetch follows WB with no gap
			wait_request(idle);
			assert (idle == 0) else
				fail_run($sformatf("** Error @ %0t: fetch %0d late by %0d cycles",
					$time, n, idle));
			check_request(1'b1, 1'b0, exp_fetch, '0, "fetch");

			// DECODE and EXE quiet
			@(negedge CLK);
			check_request(1'b0, 1'b0, '0, '0, "decode");
			@(negedge CLK);
			check_request(1'b0, 1'b0, '0, '0, "exe");
			// MEM carries the load or store, if any
			@(negedge CLK);
			if (st_en) begin
				check_request(1'b0, 1'b1, st_addr, st_data, "store");
			end else begin
				check_request(is_lw, 1'b0, ld_addr, '0, "mem");
			end
			@(negedge CLK);
			check_request(1'b0, 1'b0, '0, '0, "wb");
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
src/cpu_pkg.sv
src/phase_sequencer.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/cpu_core.sv
verif/cpu_tb.sv
